// ==== src/mac_frame_pkg.sv ====
package mac_frame_pkg;

    // ------------------------------------------------------------------------
    // GMII framing constants
    // ------------------------------------------------------------------------

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hd5;
    localparam int         PREAMBLE_LEN  = 7;
    localparam int         FCS_LEN       = 4;
    localparam int         IFG_CYCLES    = 12;  // idle cycles between frames

    // CRC-32 (802.3), reflected input, FCS sent complemented
    localparam logic [31:0] CRC_INIT    = 32'hffff_ffff;
    localparam logic [31:0] CRC_RESIDUE = 32'hc704_dd7b;
    localparam logic [31:0] CRC_POLY    = 32'h04c1_1db7;

    typedef logic [7:0] byte_t;

    // ------------------------------------------------------------------------
    // bus bundles on the GMII side
    // ------------------------------------------------------------------------

    typedef struct packed {
        byte_t data;
        logic  en;
        logic  er;
    } gmii_tx_s;

    typedef struct packed {
        byte_t data;
        logic  dv;
        logic  er;
    } gmii_rx_s;

    // one byte of CRC, first serial bit is data[0]
    function automatic logic [31:0] crc32_d8(input byte_t data, input logic [31:0] crc);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            c = {c[30:0], 1'b0} ^ ((c[31] ^ data[i]) ? CRC_POLY : 32'h0);
        end
        return c;
    endfunction

endpackage

// ==== src/packet_buffer_pkg.sv ====
package packet_buffer_pkg;
    import mac_frame_pkg::*;

    // ------------------------------------------------------------------------
    // ring geometry
    // ------------------------------------------------------------------------

    localparam int PACKET_SLOTS = 4;
    localparam int PACKET_BYTES = 64;

    typedef logic [1:0] slot_t;
    typedef logic [6:0] pkt_addr_t;  // byte index, also lengths 0..64

    typedef enum logic [2:0] {
        OP_READ       = 3'd0,
        OP_READ_LEN   = 3'd1,
        OP_READ_NEXT  = 3'd2,
        OP_WRITE      = 3'd3,
        OP_WRITE_LEN  = 3'd4,
        OP_WRITE_NEXT = 3'd5
    } host_op_e;

    typedef struct packed {
        host_op_e  op;
        pkt_addr_t address;
        byte_t     value;
    } host_cmd_s;

    // meaning of the word depends on the op that produced it
    typedef union packed {
        struct packed { logic [7:0]  pad; byte_t     data; } byte_view;
        struct packed { logic [8:0]  pad; pkt_addr_t len;  } len_view;
        struct packed { logic [14:0] pad; logic      flag; } flag_view;
    } host_result_u;

    typedef struct packed {
        logic      valid;
        pkt_addr_t index;
        byte_t     data;
    } rx_byte_wr_s;

    typedef struct packed {
        logic      valid;
        logic      good;
        pkt_addr_t length;  // payload only, FCS stripped
    } rx_frame_end_s;

endpackage

// ==== src/gmii_rx_framer.sv ====
module gmii_rx_framer
    import mac_frame_pkg::*;
    import packet_buffer_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  gmii_rx_s      gmii_rx,
    output rx_byte_wr_s   byte_wr,
    output rx_frame_end_s frame_end
);

    typedef enum logic [1:0] {HUNT, PREAMBLE, SFD, DATA} rx_state_e;

    rx_state_e   state;
    logic [2:0]  pre_count;
    pkt_addr_t   count;      // bytes after SFD, FCS included
    logic        too_long;
    logic [31:0] crc;
    logic        rx_ok;

    assign rx_ok = gmii_rx.dv && !gmii_rx.er;

    always_ff @(posedge clock) begin
        if (reset) begin
            state           <= HUNT;
            byte_wr.valid   <= 1'b0;
            frame_end.valid <= 1'b0;
        end else begin
            byte_wr.valid   <= 1'b0;
            frame_end.valid <= 1'b0;
            case (state)
                HUNT: begin
                    if (rx_ok && gmii_rx.data == PREAMBLE_BYTE) begin
                        pre_count <= 3'd1;
                        state     <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    if (!rx_ok || gmii_rx.data != PREAMBLE_BYTE)
                        state <= HUNT;
                    else if (pre_count == PREAMBLE_LEN - 1)
                        state <= SFD;
                    else
                        pre_count <= pre_count + 3'd1;
                end
                SFD: begin
                    if (rx_ok && gmii_rx.data == SFD_BYTE) begin
                        count    <= '0;
                        too_long <= 1'b0;
                        crc      <= CRC_INIT;
                        state    <= DATA;
                    end else begin
                        state <= HUNT;
                    end
                end
                DATA: begin
                    if (!gmii_rx.dv) begin
                        // end of frame, judge it
                        frame_end.valid  <= 1'b1;
                        frame_end.good   <= !too_long && count >= FCS_LEN &&
                                            crc == CRC_RESIDUE;
                        frame_end.length <= pkt_addr_t'(count - FCS_LEN);
                        state            <= HUNT;
                    end else if (gmii_rx.er) begin
                        state <= HUNT;  // aborted, never reported
                    end else begin
                        byte_wr.valid <= count < PACKET_BYTES;
                        byte_wr.index <= count;
                        byte_wr.data  <= gmii_rx.data;
                        crc           <= crc32_d8(gmii_rx.data, crc);
                        if (count == PACKET_BYTES + FCS_LEN)
                            too_long <= 1'b1;
                        else
                            count <= count + 7'd1;
                    end
                end
                default: state <= HUNT;
            endcase
        end
    end

    // ring relies on stores and commits never sharing a cycle
    a_store_not_commit: assert property (@(posedge clock) disable iff (reset)
        !(byte_wr.valid && frame_end.valid));

endmodule

// ==== src/rx_packet_ring.sv ====
module rx_packet_ring
    import mac_frame_pkg::*;
    import packet_buffer_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  rx_byte_wr_s   byte_wr,
    input  rx_frame_end_s frame_end,
    input  host_op_e      rd_op,
    input  logic          rd_strobe,
    input  pkt_addr_t     rd_addr,
    output host_result_u  rd_result
);

    byte_t     mem [PACKET_SLOTS][PACKET_BYTES];
    pkt_addr_t len [PACKET_SLOTS];

    slot_t recv_ptr;  // slot being filled by the framer
    slot_t read_ptr;  // oldest held packet
    logic  empty;
    logic  full;
    logic  commit;

    assign empty  = read_ptr == recv_ptr;
    assign full   = slot_t'(recv_ptr + 2'd1) == read_ptr;
    assign commit = frame_end.valid && frame_end.good && !full;  // lost when full

    always_ff @(posedge clock) begin
        if (byte_wr.valid)
            mem[recv_ptr][byte_wr.index[5:0]] <= byte_wr.data;
        if (commit)
            len[recv_ptr] <= frame_end.length;
    end

    // ------------------------------------------------------------------------
    // pointers
    // ------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            recv_ptr <= '0;
            read_ptr <= '0;
        end else begin
            if (commit)
                recv_ptr <= recv_ptr + 2'd1;
            if (rd_strobe && rd_op == OP_READ_NEXT && !empty)
                read_ptr <= read_ptr + 2'd1;
        end
    end

    // host side results, zero when nothing is held
    always_comb begin
        rd_result = '0;
        case (rd_op)
            OP_READ: begin
                if (!empty && rd_addr < len[read_ptr])
                    rd_result.byte_view.data = mem[read_ptr][rd_addr[5:0]];
            end
            OP_READ_LEN: begin
                if (!empty)
                    rd_result.len_view.len = len[read_ptr];
            end
            OP_READ_NEXT: rd_result.flag_view.flag = empty;
            default: ;
        endcase
    end

endmodule

// ==== src/host_port.sv ====
module host_port
    import mac_frame_pkg::*;
    import packet_buffer_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         start,
    input  host_cmd_s    cmd,
    output host_op_e     rd_op,
    output logic         rd_strobe,
    output pkt_addr_t    rd_addr,
    output host_op_e     wr_op,
    output logic         wr_strobe,
    output pkt_addr_t    wr_addr,
    output byte_t        wr_value,
    input  host_result_u rd_result,
    input  host_result_u wr_result,
    output logic         done,
    output host_result_u result
);

    logic rd_group;

    assign rd_group = cmd.op inside {OP_READ, OP_READ_LEN, OP_READ_NEXT};

    assign rd_op     = cmd.op;
    assign rd_addr   = cmd.address;
    assign rd_strobe = start && rd_group;
    assign wr_op     = cmd.op;
    assign wr_addr   = cmd.address;
    assign wr_value  = cmd.value;
    assign wr_strobe = start && !rd_group;

    always_ff @(posedge clock) begin
        if (reset)
            done <= 1'b0;
        else
            done <= start;  // fixed one cycle latency
    end

    always_ff @(posedge clock) begin
        if (start)
            result <= rd_group ? rd_result : wr_result;
    end

    a_legal_op: assert property (@(posedge clock) disable iff (reset)
        start |-> cmd.op inside {OP_READ, OP_READ_LEN, OP_READ_NEXT,
                                 OP_WRITE, OP_WRITE_LEN, OP_WRITE_NEXT});

endmodule

// ==== src/tx_packet_ring.sv ====
module tx_packet_ring
    import mac_frame_pkg::*;
    import packet_buffer_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  host_op_e     wr_op,
    input  logic         wr_strobe,
    input  pkt_addr_t    wr_addr,
    input  byte_t        wr_value,
    output host_result_u wr_result,
    input  pkt_addr_t    tx_index,
    input  logic         frame_sent,
    output logic         pending,
    output pkt_addr_t    tx_len,
    output byte_t        tx_byte
);

    byte_t     mem [PACKET_SLOTS][PACKET_BYTES];
    pkt_addr_t len [PACKET_SLOTS];

    slot_t fill_ptr;   // slot the host is writing
    slot_t sent_ptr;   // next slot to go out
    slot_t next_fill;
    logic  full;
    logic  in_range;

    assign next_fill = fill_ptr + 2'd1;
    assign full      = next_fill == sent_ptr;
    assign in_range  = wr_addr < PACKET_BYTES;

    assign pending = sent_ptr != fill_ptr;
    assign tx_len  = len[sent_ptr];
    assign tx_byte = mem[sent_ptr][tx_index[5:0]];

    always_ff @(posedge clock) begin
        if (wr_strobe && wr_op == OP_WRITE && in_range)
            mem[fill_ptr][wr_addr[5:0]] <= wr_value;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fill_ptr <= '0;
            sent_ptr <= '0;
            for (int i = 0; i < PACKET_SLOTS; i++)
                len[i] <= '0;
        end else begin
            if (frame_sent)
                sent_ptr <= sent_ptr + 2'd1;
            if (wr_strobe && wr_op == OP_WRITE && in_range && wr_addr >= len[fill_ptr])
                len[fill_ptr] <= wr_addr + 7'd1;  // grow to cover the write
            if (wr_strobe && wr_op == OP_WRITE_NEXT && !full) begin
                fill_ptr       <= next_fill;
                len[next_fill] <= '0;
            end
        end
    end

    always_comb begin
        wr_result = '0;
        case (wr_op)
            OP_WRITE:      wr_result.flag_view.flag = !in_range;
            OP_WRITE_LEN:  wr_result.len_view.len   = len[fill_ptr];
            OP_WRITE_NEXT: wr_result.flag_view.flag = full;  // overflow
            default: ;
        endcase
    end

endmodule

// ==== src/gmii_tx_framer.sv ====
module gmii_tx_framer
    import mac_frame_pkg::*;
    import packet_buffer_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      pending,
    input  pkt_addr_t tx_len,
    input  byte_t     tx_byte,
    output pkt_addr_t tx_index,
    output logic      frame_sent,
    output gmii_tx_s  gmii_tx
);

    typedef enum logic [2:0] {IDLE, PREAMBLE, DATA, FCS, GAP} tx_state_e;

    tx_state_e   state;
    logic [3:0]  step;      // preamble, FCS and gap counter
    pkt_addr_t   index;
    logic [31:0] crc;
    logic [31:0] crc_rev;
    logic [23:0] fcs_rest;  // FCS bytes still to send

    assign crc_rev  = {<<{crc}};
    assign tx_index = index;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= IDLE;
            gmii_tx.en <= 1'b0;
            gmii_tx.er <= 1'b0;
            frame_sent <= 1'b0;
        end else begin
            frame_sent <= 1'b0;
            case (state)
                IDLE: begin
                    gmii_tx.en <= pending;
                    if (pending) begin
                        gmii_tx.data <= PREAMBLE_BYTE;
                        step         <= 4'd1;
                        state        <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    step <= step + 4'd1;
                    if (step == PREAMBLE_LEN) begin
                        gmii_tx.data <= SFD_BYTE;
                        index        <= '0;
                        crc          <= CRC_INIT;
                        state        <= DATA;
                    end else begin
                        gmii_tx.data <= PREAMBLE_BYTE;
                    end
                end
                DATA: begin
                    if (index < tx_len) begin
                        gmii_tx.data <= tx_byte;
                        crc          <= crc32_d8(tx_byte, crc);
                        index        <= index + 7'd1;
                    end else begin
                        // first FCS byte goes out right after the payload
                        gmii_tx.data <= ~crc_rev[7:0];
                        fcs_rest     <= ~crc_rev[31:8];
                        step         <= 4'd1;
                        state        <= FCS;
                    end
                end
                FCS: begin
                    gmii_tx.data <= fcs_rest[7:0];
                    fcs_rest     <= fcs_rest >> 8;
                    step         <= step + 4'd1;
                    if (step == FCS_LEN - 1) begin
                        frame_sent <= 1'b1;
                        step       <= '0;
                        state      <= GAP;
                    end
                end
                GAP: begin
                    gmii_tx.en <= 1'b0;
                    step       <= step + 4'd1;
                    if (step == IFG_CYCLES - 1)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // en held low a full gap before the next frame starts
    a_gap_low: assert property (@(posedge clock) disable iff (reset)
        $rose(gmii_tx.en) |-> $past(!gmii_tx.en, IFG_CYCLES));

endmodule

// ==== src/eth_packet_mac.sv ====
module eth_packet_mac
    import mac_frame_pkg::*;
    import packet_buffer_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         start,
    input  host_cmd_s    cmd,
    output logic         done,
    output host_result_u result,
    input  gmii_rx_s     gmii_rx,
    output gmii_tx_s     gmii_tx
);

    // host side
    host_op_e      rd_op;
    logic          rd_strobe;
    pkt_addr_t     rd_addr;
    host_result_u  rd_result;
    host_op_e      wr_op;
    logic          wr_strobe;
    pkt_addr_t     wr_addr;
    byte_t         wr_value;
    host_result_u  wr_result;

    // line side
    rx_byte_wr_s   byte_wr;
    rx_frame_end_s frame_end;
    pkt_addr_t     tx_index;
    logic          frame_sent;
    logic          pending;
    pkt_addr_t     tx_len;
    byte_t         tx_byte;

    gmii_rx_framer gmii_rx_framer_inst (
        .clock(clock), .reset(reset),
        .gmii_rx(gmii_rx), .byte_wr(byte_wr), .frame_end(frame_end)
    );

    rx_packet_ring rx_packet_ring_inst (
        .clock(clock), .reset(reset),
        .byte_wr(byte_wr), .frame_end(frame_end),
        .rd_op(rd_op), .rd_strobe(rd_strobe), .rd_addr(rd_addr), .rd_result(rd_result)
    );

    host_port host_port_inst (
        .clock(clock), .reset(reset), .start(start), .cmd(cmd),
        .rd_op(rd_op), .rd_strobe(rd_strobe), .rd_addr(rd_addr),
        .wr_op(wr_op), .wr_strobe(wr_strobe), .wr_addr(wr_addr), .wr_value(wr_value),
        .rd_result(rd_result), .wr_result(wr_result), .done(done), .result(result)
    );

    tx_packet_ring tx_packet_ring_inst (
        .clock(clock), .reset(reset),
        .wr_op(wr_op), .wr_strobe(wr_strobe), .wr_addr(wr_addr), .wr_value(wr_value),
        .wr_result(wr_result), .tx_index(tx_index), .frame_sent(frame_sent),
        .pending(pending), .tx_len(tx_len), .tx_byte(tx_byte)
    );

    gmii_tx_framer gmii_tx_framer_inst (
        .clock(clock), .reset(reset),
        .pending(pending), .tx_len(tx_len), .tx_byte(tx_byte),
        .tx_index(tx_index), .frame_sent(frame_sent), .gmii_tx(gmii_tx)
    );

endmodule

// ==== verification/eth_packet_mac_tb.sv ====
module eth_packet_mac_tb
    import mac_frame_pkg::*;
    import packet_buffer_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // run limit from frame lengths and command counts
    localparam int TX_CYCLES = 4 * (PREAMBLE_LEN + 1 + FCS_LEN + IFG_CYCLES) + 10 + 40 + 3 + 3;
    localparam int RX_CYCLES = 3 * (PREAMBLE_LEN + 1 + FCS_LEN + 3) + 20 + 16 + 16;
    localparam int CMD_COUNT = 89;
    localparam int TIMEOUT_CYCLES = 2 * (TX_CYCLES + RX_CYCLES + 3 * CMD_COUNT) + 100;

    logic         clock;
    logic         reset;
    logic         start;
    host_cmd_s    cmd;
    logic         done;
    host_result_u result;
    gmii_rx_s     gmii_rx;
    gmii_tx_s     gmii_tx;

    logic [31:0]  lfsr_state = 32'h4af5;
    int           cycle_count = 0;
    host_cmd_s    cmd_q[$];
    host_result_u res_q[$];
    byte_t        tx_payload[$];
    byte_t        tx_seen[$];       // every byte sampled with en high
    int           tx_frame_len[$];  // en run length of each finished frame
    int           tx_run = 0;
    int           tx_low = IFG_CYCLES;
    int           tx_offset = 0;

    eth_packet_mac eth_packet_mac_inst (
        .clock(clock), .reset(reset), .start(start), .cmd(cmd), .done(done),
        .result(result), .gmii_rx(gmii_rx), .gmii_tx(gmii_tx)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ------------------------------------------------------------------------
    // failure reporting and compares
    // ------------------------------------------------------------------------

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        stop_failed($sformatf("ERR %0t: %s", $time, msg));
    endtask

    task automatic check_result(input host_result_u got, input host_result_u exp,
                                input bit is_flag, input string what);
        if (is_flag && got.flag_view.flag !== exp.flag_view.flag)
            report_mismatch($sformatf("%s flag %0b, expected %0b", what,
                                      got.flag_view.flag, exp.flag_view.flag));
        else if (!is_flag && got.byte_view.data !== exp.byte_view.data)
            report_mismatch($sformatf("%s byte %h, expected %h", what,
                                      got.byte_view.data, exp.byte_view.data));
    endtask

    task automatic check_len(input pkt_addr_t got, input pkt_addr_t exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_tx_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s %h, expected %h", what, got, exp));
    endtask

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic byte_t rand_byte();
        byte_t b;
        for (int i = 0; i < 8; i++)
            b[i] = lfsr_bit();
        return b;
    endfunction

    // reflected form with the register shifting right
    function automatic logic [31:0] ref_fcs(input byte_t bytes[$]);
        logic [31:0] c;
        c = 32'hffff_ffff;
        foreach (bytes[i]) begin
            c = c ^ {24'h0, bytes[i]};
            for (int k = 0; k < 8; k++)
                c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
        end
        return ~c;
    endfunction

    task automatic build_wire_frame(input byte_t payload[$], output byte_t frame[$]);
        logic [31:0] fcs;
        fcs = ref_fcs(payload);
        frame = {};
        repeat (PREAMBLE_LEN) frame.push_back(PREAMBLE_BYTE);
        frame.push_back(SFD_BYTE);
        foreach (payload[i])
            frame.push_back(payload[i]);
        for (int k = 0; k < FCS_LEN; k++)
            frame.push_back(fcs[8*k +: 8]);  // low byte first
    endtask

    // er held from err_at to the end of the frame unless err_at is negative
    task automatic inject_rx_frame(input byte_t frame[$], input int err_at);
        foreach (frame[i]) begin
            @(posedge clock);
            gmii_rx.data <= frame[i];
            gmii_rx.dv   <= 1'b1;
            gmii_rx.er   <= err_at >= 0 && i >= err_at;
        end
        @(posedge clock);
        gmii_rx <= '0;
        repeat (2) @(posedge clock);  // frame_end and then the commit
    endtask

    task automatic push_cmd(input host_op_e op, input int addr, input byte_t value);
        host_cmd_s c;
        c.op      = op;
        c.address = pkt_addr_t'(addr);
        c.value   = value;
        cmd_q.push_back(c);
    endtask

    // queued commands go out back to back with one result per done cycle
    task automatic run_commands();
        int sent;
        int cycles;
        sent = 0;
        cycles = 0;
        res_q.delete();
        while (res_q.size() < cmd_q.size()) begin
            @(posedge clock);
            // done trails each start by one cycle
            if (done !== (cycles >= 2))
                report_mismatch($sformatf("done %0b in command cycle %0d, expected %0b",
                                          done, cycles, cycles >= 2));
            if (done)
                res_q.push_back(result);
            if (sent < cmd_q.size()) begin
                start <= 1'b1;
                cmd   <= cmd_q[sent];
                sent++;
            end else begin
                start <= 1'b0;
            end
            cycles++;
        end
        start <= 1'b0;
        cmd_q.delete();
    endtask

    task automatic check_tx_frame(input byte_t payload[$], input string what);
        byte_t exp[$];
        int    got_len;
        build_wire_frame(payload, exp);
        while (tx_frame_len.size() == 0)
            @(negedge clock);
        got_len = tx_frame_len.pop_front();
        check_len(pkt_addr_t'(got_len), pkt_addr_t'(exp.size()), {what, " en cycles"});
        foreach (exp[i])
            check_tx_byte(tx_seen[tx_offset + i], exp[i], $sformatf("%s byte %0d", what, i));
        tx_offset += got_len;
    endtask

    // write into the fill slot and then attempt write_next back to back
    task automatic fill_and_commit(input byte_t payload[$], input int attempts,
                                   inout int in_ring);
        host_result_u exp;
        foreach (payload[i])
            push_cmd(OP_WRITE, i, payload[i]);
        repeat (attempts) push_cmd(OP_WRITE_NEXT, 0, 8'h00);
        run_commands();
        exp = '0;
        foreach (payload[i])
            check_result(res_q[i], exp, 1'b1, $sformatf("write at %0d", i));
        for (int k = 0; k < attempts; k++) begin
            exp.flag_view.flag = in_ring == PACKET_SLOTS - 1;  // full ring
            check_result(res_q[payload.size() + k], exp, 1'b1, "write_next overflow");
            if (!exp.flag_view.flag)
                in_ring++;
        end
    endtask

    // ------------------------------------------------------------------------
    // monitors
    // ------------------------------------------------------------------------

    always @(posedge clock) begin
        if (reset) begin
            tx_run = 0;
            tx_low = IFG_CYCLES;
        end else if (gmii_tx.en) begin
            if (tx_run == 0 && tx_low < IFG_CYCLES)
                report_mismatch($sformatf("tx en rose after %0d idle cycles", tx_low));
            if (gmii_tx.er)
                report_mismatch("tx er high during a frame");
            tx_seen.push_back(gmii_tx.data);
            tx_run++;
            tx_low = 0;
        end else begin
            if (tx_run != 0)
                tx_frame_len.push_back(tx_run);
            tx_run = 0;
            tx_low++;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
            stop_failed($sformatf("timeout: run passed %0d cycles", TIMEOUT_CYCLES));
    end

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------

    task automatic test_write_len();
        host_result_u exp;
        for (int a = 0; a < 10; a++) begin
            tx_payload.push_back(rand_byte());
            push_cmd(OP_WRITE, a, tx_payload[a]);
        end
        push_cmd(OP_WRITE, PACKET_BYTES, 8'hff);
        push_cmd(OP_WRITE_LEN, 0, 8'h00);
        run_commands();
        exp = '0;
        for (int a = 0; a < 10; a++)
            check_result(res_q[a], exp, 1'b1, $sformatf("write at %0d", a));
        exp.flag_view.flag = 1'b1;
        check_result(res_q[10], exp, 1'b1, "write past the slot");
        check_len(res_q[11].len_view.len, 7'd10, "write_len");
    endtask

    task automatic test_transmit();
        host_result_u exp;
        push_cmd(OP_WRITE_NEXT, 0, 8'h00);
        run_commands();
        exp = '0;
        check_result(res_q[0], exp, 1'b1, "write_next");
        check_tx_frame(tx_payload, "frame 0");
        repeat (IFG_CYCLES) @(negedge clock);
        if (tx_low < IFG_CYCLES)
            report_mismatch($sformatf("en low for only %0d cycles after frame 0", tx_low));
    endtask

    task automatic test_receive();
        byte_t        payload[$];
        byte_t        frame[$];
        host_result_u exp;
        for (int i = 0; i < 20; i++)
            payload.push_back(rand_byte());
        build_wire_frame(payload, frame);
        inject_rx_frame(frame, -1);
        push_cmd(OP_READ_LEN, 0, 8'h00);
        for (int a = 0; a <= 20; a++)
            push_cmd(OP_READ, a, 8'h00);
        push_cmd(OP_READ_NEXT, 0, 8'h00);
        push_cmd(OP_READ_NEXT, 0, 8'h00);
        run_commands();
        check_len(res_q[0].len_view.len, 7'd20, "read_len");
        exp = '0;
        for (int a = 0; a <= 20; a++) begin
            if (a < 20)
                exp.byte_view.data = payload[a];
            else
                exp.byte_view.data = 8'h00;  // past the stored length
            check_result(res_q[a + 1], exp, 1'b0, $sformatf("read at %0d", a));
        end
        exp = '0;
        check_result(res_q[22], exp, 1'b1, "first read_next");
        exp.flag_view.flag = 1'b1;
        check_result(res_q[23], exp, 1'b1, "second read_next");
    endtask

    task automatic test_bad_frames();
        byte_t        payload[$];
        byte_t        frame[$];
        host_result_u exp;
        for (int i = 0; i < 16; i++)
            payload.push_back(rand_byte());
        build_wire_frame(payload, frame);
        frame[frame.size() - 1] = frame[frame.size() - 1] ^ 8'h01;
        inject_rx_frame(frame, -1);
        build_wire_frame(payload, frame);
        inject_rx_frame(frame, PREAMBLE_LEN + 1 + 5);
        push_cmd(OP_READ_LEN, 0, 8'h00);
        push_cmd(OP_READ_NEXT, 0, 8'h00);
        run_commands();
        check_len(res_q[0].len_view.len, 7'd0, "read_len after bad frames");
        exp = '0;
        exp.flag_view.flag = 1'b1;
        check_result(res_q[1], exp, 1'b1, "read_next after bad frames");
    endtask

    task automatic test_overflow();
        byte_t slot_a[$];
        byte_t slot_b[$];
        byte_t slot_c[$];
        int    in_ring;
        for (int i = 0; i < 40; i++)
            slot_a.push_back(rand_byte());
        for (int i = 0; i < 3; i++) begin
            slot_b.push_back(rand_byte());
            slot_c.push_back(rand_byte());
        end
        in_ring = 0;
        // long first frame keeps the framer busy while the ring fills
        fill_and_commit(slot_a, 1, in_ring);
        fill_and_commit(slot_b, 1, in_ring);
        fill_and_commit(slot_c, 2, in_ring);
        if (tx_frame_len.size() != 0)
            stop_failed("a frame finished before the transmit ring filled");
        check_tx_frame(slot_a, "frame a");
        check_tx_frame(slot_b, "frame b");
        check_tx_frame(slot_c, "frame c");
        repeat (2 * IFG_CYCLES) @(negedge clock);
        if (tx_frame_len.size() != 0 || tx_run != 0)
            report_mismatch("extra frame sent after the overflow attempt");
    endtask

    initial begin
        reset   = 1'b1;
        start   = 1'b0;
        cmd     = '0;
        gmii_rx = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        if (gmii_tx.en || gmii_tx.er || done)
            report_mismatch("outputs not idle after reset");
        test_write_len();
        test_transmit();
        test_receive();
        test_bad_frames();
        test_overflow();
        $display("No errors");
        $finish;
    end

endmodule

// ==== compile.f ====
src/mac_frame_pkg.sv
src/packet_buffer_pkg.sv
src/gmii_rx_framer.sv
src/rx_packet_ring.sv
src/host_port.sv
src/tx_packet_ring.sv
src/gmii_tx_framer.sv
src/eth_packet_mac.sv
verification/eth_packet_mac_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the MAC testbench with Verilator
set -u

cd "$(dirname "$0")" || { echo "cannot enter project root"; exit 1; }

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
        --top-module eth_packet_mac_tb -f compile.f -o eth_packet_mac_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/eth_packet_mac_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -eq 0 ] && grep -q "^No errors$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
